// ==== dv/cobs_encode_tb.sv ====
// testbench for the COBS stream encoder
// random frames in, random back-pressure out, output checked against the model

`timescale 1ns/1ps

module cobs_encode_tb;

    logic               clk = 1'b0;
    logic               rst = 1'b1;
    stream_pkg::byte_t  s_tdata = '0;
    logic               s_tvalid = 1'b0;
    logic               s_tready;
    logic               s_tlast = 1'b0;
    stream_pkg::byte_t  m_tdata;
    logic               m_tvalid;
    logic               m_tready = 1'b0;
    logic               m_tlast;

    // all frames back to back, lengths kept separately
    stream_pkg::byte_t  stim_q[$];
    int                 frame_len[$];
    int                 cur_len = 0;
    // expected output as {last, byte}
    logic [8:0]         exp_q[$];
    logic [8:0]         exp_byte;
    bit                 sent_any = 1'b0;
    int                 cycle_count = 0;
    int                 cycle_limit = 1000;
    int                 zero_pcts[4] = '{0, 10, 50, 90};

    cobs_encode i_dut (
        .clk      (clk),
        .rst      (rst),
        .s_tdata  (s_tdata),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .s_tlast  (s_tlast),
        .m_tdata  (m_tdata),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .m_tlast  (m_tlast)
    );

    always #20 clk = ~clk;

    task automatic fail_run(string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(string sig, logic [7:0] exp, logic [7:0] act);
        fail_run($sformatf("Mismatch at %0t: %s expected 0x%02h actual 0x%02h",
                           $time, sig, exp, act));
    endtask

    // append len bytes to the current frame, zero_pct percent of them zero
    function automatic void push_run(int len, int zero_pct);
        for (int i = 0; i < len; i++) begin
            if ($urandom_range(99) < zero_pct) begin
                stim_q.push_back(8'h00);
            end else begin
                stim_q.push_back(stream_pkg::byte_t'($urandom_range(255, 1)));
            end
        end
        cur_len += len;
    endfunction

    function automatic void end_frame();
        frame_len.push_back(cur_len);
        cur_len = 0;
    endfunction

    // queue the expected encoding, then present the bytes with random gaps
    task automatic send_frame(int start, int len);
        cobs_model::byte_q_t frame;
        cobs_model::byte_q_t enc;

        for (int i = 0; i < len; i++) begin
            frame.push_back(stim_q[start + i]);
        end
        enc = cobs_model::encode(frame);
        foreach (enc[k]) begin
            exp_q.push_back({k == enc.size() - 1, enc[k]});
        end

        for (int i = 0; i < len; i++) begin
            if ($urandom_range(3) == 0) begin
                s_tvalid = 1'b0;
                repeat ($urandom_range(3, 1)) begin
                    @(posedge clk);
                    #2;
                end
            end
            s_tdata  = frame[i];
            s_tlast  = (i == len - 1);
            s_tvalid = 1'b1;
            @(negedge clk);
            while (!s_tready) begin
                @(negedge clk);
            end
            @(posedge clk);
            #2;
            sent_any = 1'b1;
        end
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
    endtask

    // values are settled at the falling edge, the transfer follows on the rising one
    always @(negedge clk) begin
        if (!rst) begin
            assert (sent_any || !m_tvalid)
                else fail_run("m_tvalid went high before any input byte was sent");
            if (m_tvalid && m_tready) begin
                assert (exp_q.size() != 0)
                    else fail_run("output byte arrived when no byte was expected");
                exp_byte = exp_q.pop_front();
                assert (m_tdata == exp_byte[7:0])
                    else report_mismatch("m_tdata", exp_byte[7:0], m_tdata);
                assert (m_tlast == exp_byte[8])
                    else report_mismatch("m_tlast", {7'd0, exp_byte[8]}, {7'd0, m_tlast});
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            fail_run("timeout: output did not finish within the cycle limit");
        end
    end

    initial begin
        int start;
        int runs;

        void'($urandom(32'h3581));

        // short frames, single bytes, zeros at both ends
        push_run(1, 0);
        end_frame();
        push_run(3, 0);
        end_frame();
        push_run(1, 100);
        end_frame();
        push_run(2, 100);
        end_frame();
        push_run(2, 100);
        push_run(5, 0);
        push_run(3, 100);
        push_run(4, 0);
        push_run(1, 100);
        end_frame();
        // group limit around 254
        push_run(253, 0);
        end_frame();
        push_run(254, 0);
        end_frame();
        push_run(255, 0);
        end_frame();
        push_run(254, 0);
        push_run(1, 100);
        end_frame();
        push_run(508, 0);
        end_frame();
        push_run(600, 0);
        push_run(1, 100);
        push_run(254, 0);
        end_frame();
        // random frames of mixed runs
        repeat (40) begin
            runs = $urandom_range(4, 1);
            repeat (runs) begin
                push_run($urandom_range(150, 1), zero_pcts[$urandom_range(3)]);
            end
            end_frame();
        end
        cycle_limit = stim_q.size() * 8 + 1000;

        fork
            forever begin
                @(posedge clk);
                #2;
                m_tready = ($urandom_range(9) < 6);
            end
        join_none

        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        // idle a while, output must stay quiet
        repeat (6) @(posedge clk);
        #2;

        start = 0;
        foreach (frame_len[f]) begin
            send_frame(start, frame_len[f]);
            start += frame_len[f];
        end

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);

        if (exp_q.size() == 0 && !m_tvalid) begin
            $display("TB PASSED");
            $finish;
        end else begin
            fail_run("output still valid after the last expected byte");
        end
    end

endmodule

// ==== dv/cobs_model.sv ====
// reference COBS encoder for the testbench
// encodes one frame held in a byte queue, terminator included

package cobs_model;

    typedef stream_pkg::byte_t byte_q_t[$];

    // nonzero bytes in a full group
    localparam int GROUP_MAX = 254;

    // frame in, encoded bytes plus the appended zero out
    function automatic byte_q_t encode(input byte_q_t frame);
        byte_q_t enc;
        int      code_idx;
        int      code;
        bit      just_full;

        // slot for the first group's code, filled in when the group closes
        enc.push_back(8'h00);
        code_idx  = 0;
        code      = 1;
        just_full = 1'b0;

        foreach (frame[i]) begin
            if (frame[i] == 8'h00) begin
                enc[code_idx] = stream_pkg::byte_t'(code);
                code_idx      = enc.size();
                enc.push_back(8'h00);
                code          = 1;
                just_full     = 1'b0;
            end else begin
                enc.push_back(frame[i]);
                code      = code + 1;
                just_full = 1'b0;
                // full group, closed with no implied zero
                if (code == GROUP_MAX + 1) begin
                    enc[code_idx] = stream_pkg::byte_t'(GROUP_MAX + 1);
                    code_idx      = enc.size();
                    enc.push_back(8'h00);
                    code          = 1;
                    just_full     = 1'b1;
                end
            end
        end

        // a frame that ends right on a full group gets no extra code
        if (just_full) begin
            void'(enc.pop_back());
        end else begin
            enc[code_idx] = stream_pkg::byte_t'(code);
        end
        enc.push_back(8'h00);
        return enc;
    endfunction

endpackage

// ==== hdl/byte_fifo.sv ====
// byte FIFO with last flag
// valid/ready on both sides, registered output stage

`timescale 1ns/1ps

`include "cobs_macros.svh"

module byte_fifo (
    input  logic               clk,
    input  logic               rst,
    input  stream_pkg::byte_t  in_tdata,
    input  logic               in_tlast,
    input  logic               in_tvalid,
    output logic               in_tready,
    output stream_pkg::byte_t  out_tdata,
    output logic               out_tlast,
    output logic               out_tvalid,
    input  logic               out_tready
);

    stream_pkg::byte_t          mem_data [`COBS_FIFO_DEPTH];
    logic                       mem_last [`COBS_FIFO_DEPTH];
    logic [`COBS_FIFO_AW:0]     wr_ptr;
    logic [`COBS_FIFO_AW:0]     rd_ptr;
    logic [`COBS_FIFO_AW:0]     fill;
    logic                       empty;
    logic                       full;
    logic                       load_out;
    logic                       mem_rd;
    logic                       mem_wr;
    logic                       bypass;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[`COBS_FIFO_AW] != rd_ptr[`COBS_FIFO_AW]) &&
                   (wr_ptr[`COBS_FIFO_AW-1:0] == rd_ptr[`COBS_FIFO_AW-1:0]);
    assign in_tready = !full;
    // entries held in memory, output slot not counted
    assign fill = wr_ptr - rd_ptr;

    // output slot is free or being drained this cycle
    assign load_out = !out_tvalid || out_tready;
    assign mem_rd   = load_out && !empty;
    // nothing queued, so the new byte goes straight to the output
    assign bypass   = load_out && empty && in_tvalid;
    assign mem_wr   = in_tvalid && in_tready && !bypass;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            out_tvalid <= 1'b0;
        end else begin
            if (mem_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (mem_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (load_out) begin
                out_tvalid <= mem_rd || bypass;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wr) begin
            mem_data[wr_ptr[`COBS_FIFO_AW-1:0]] <= in_tdata;
            mem_last[wr_ptr[`COBS_FIFO_AW-1:0]] <= in_tlast;
        end
        if (mem_rd) begin
            out_tdata <= mem_data[rd_ptr[`COBS_FIFO_AW-1:0]];
            out_tlast <= mem_last[rd_ptr[`COBS_FIFO_AW-1:0]];
        end else if (bypass) begin
            out_tdata <= in_tdata;
            out_tlast <= in_tlast;
        end
    end

    // occupancy never passes the depth, so a full FIFO takes no write
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        fill <= `COBS_FIFO_DEPTH);

endmodule

// ==== hdl/cobs_emitter.sv ====
// COBS output emitter
// sends a code, then the data bytes that code announces

`timescale 1ns/1ps

module cobs_emitter (
    input  logic               clk,
    input  logic               rst,
    input  stream_pkg::byte_t  code_tdata,
    input  logic               code_tlast,
    input  logic               code_tvalid,
    output logic               code_tready,
    input  stream_pkg::byte_t  data_tdata,
    input  logic               data_tvalid,
    output logic               data_tready,
    output stream_pkg::byte_t  int_tdata,
    output logic               int_tvalid,
    output logic               int_tlast,
    input  logic               int_tready
);

    cobs_pkg::emit_state_t  state;
    cobs_pkg::emit_state_t  state_next;
    // data bytes still owed to the current group
    stream_pkg::byte_t      cnt;
    stream_pkg::byte_t      cnt_next;

    always_comb begin
        state_next  = state;
        cnt_next    = cnt;
        int_tdata   = code_tdata;
        int_tvalid  = 1'b0;
        int_tlast   = 1'b0;
        code_tready = 1'b0;
        data_tready = 1'b0;

        case (state)
            cobs_pkg::EMIT_CODE: begin
                if (int_tready && code_tvalid) begin
                    int_tvalid  = 1'b1;
                    int_tlast   = code_tlast;
                    code_tready = 1'b1;
                    cnt_next    = code_tdata - 1'b1;
                    // terminator and empty group carry no data
                    if (code_tdata != cobs_pkg::CODE_TERM &&
                        code_tdata != cobs_pkg::CODE_EMPTY) begin
                        state_next = cobs_pkg::EMIT_DATA;
                    end
                end
            end
            default: begin
                if (int_tready && data_tvalid) begin
                    int_tdata   = data_tdata;
                    int_tvalid  = 1'b1;
                    data_tready = 1'b1;
                    cnt_next    = cnt - 1'b1;
                    if (cnt == 8'd1) begin
                        state_next = cobs_pkg::EMIT_CODE;
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cobs_pkg::EMIT_CODE;
            cnt   <= '0;
        end else begin
            state <= state_next;
            cnt   <= cnt_next;
        end
    end

    // data is pulled only inside a group that still owes bytes
    a_data_in_group: assert property (@(posedge clk) disable iff (rst)
        data_tready |-> state == cobs_pkg::EMIT_DATA && cnt != '0);

endmodule

// ==== hdl/cobs_encode.sv ====
// COBS stream encoder top
// segmenter, data and code FIFOs, emitter and output skid buffer

`timescale 1ns/1ps

module cobs_encode (
    input  logic               clk,
    input  logic               rst,
    input  stream_pkg::byte_t  s_tdata,
    input  logic               s_tvalid,
    output logic               s_tready,
    input  logic               s_tlast,
    output stream_pkg::byte_t  m_tdata,
    output logic               m_tvalid,
    input  logic               m_tready,
    output logic               m_tlast
);

    stream_pkg::byte_t  data_in_tdata;
    logic               data_in_tvalid;
    logic               data_in_tready;
    stream_pkg::byte_t  data_out_tdata;
    logic               data_out_tvalid;
    logic               data_out_tready;

    stream_pkg::byte_t  code_in_tdata;
    logic               code_in_tvalid;
    logic               code_in_tlast;
    logic               code_in_tready;
    stream_pkg::byte_t  code_out_tdata;
    logic               code_out_tvalid;
    logic               code_out_tlast;
    logic               code_out_tready;

    stream_pkg::byte_t  int_tdata;
    logic               int_tvalid;
    logic               int_tlast;
    logic               int_tready;

    cobs_segmenter i_segmenter (
        .clk         (clk),
        .rst         (rst),
        .s_tdata     (s_tdata),
        .s_tvalid    (s_tvalid),
        .s_tready    (s_tready),
        .s_tlast     (s_tlast),
        .data_tdata  (data_in_tdata),
        .data_tvalid (data_in_tvalid),
        .data_tready (data_in_tready),
        .code_tdata  (code_in_tdata),
        .code_tvalid (code_in_tvalid),
        .code_tlast  (code_in_tlast),
        .code_tready (code_in_tready)
    );

    // frame end travels on the code path only
    byte_fifo i_data_fifo (
        .clk        (clk),
        .rst        (rst),
        .in_tdata   (data_in_tdata),
        .in_tlast   (1'b0),
        .in_tvalid  (data_in_tvalid),
        .in_tready  (data_in_tready),
        .out_tdata  (data_out_tdata),
        .out_tlast  (),
        .out_tvalid (data_out_tvalid),
        .out_tready (data_out_tready)
    );

    byte_fifo i_code_fifo (
        .clk        (clk),
        .rst        (rst),
        .in_tdata   (code_in_tdata),
        .in_tlast   (code_in_tlast),
        .in_tvalid  (code_in_tvalid),
        .in_tready  (code_in_tready),
        .out_tdata  (code_out_tdata),
        .out_tlast  (code_out_tlast),
        .out_tvalid (code_out_tvalid),
        .out_tready (code_out_tready)
    );

    cobs_emitter i_emitter (
        .clk         (clk),
        .rst         (rst),
        .code_tdata  (code_out_tdata),
        .code_tlast  (code_out_tlast),
        .code_tvalid (code_out_tvalid),
        .code_tready (code_out_tready),
        .data_tdata  (data_out_tdata),
        .data_tvalid (data_out_tvalid),
        .data_tready (data_out_tready),
        .int_tdata   (int_tdata),
        .int_tvalid  (int_tvalid),
        .int_tlast   (int_tlast),
        .int_tready  (int_tready)
    );

    skid_buffer i_skid_buffer (
        .clk        (clk),
        .rst        (rst),
        .int_tdata  (int_tdata),
        .int_tvalid (int_tvalid),
        .int_tlast  (int_tlast),
        .int_tready (int_tready),
        .m_tdata    (m_tdata),
        .m_tvalid   (m_tvalid),
        .m_tlast    (m_tlast),
        .m_tready   (m_tready)
    );

endmodule

// ==== hdl/cobs_macros.svh ====
// COBS encoder build constants
// byte width, FIFO sizing and the full-group code

`ifndef COBS_MACROS_SVH
`define COBS_MACROS_SVH

// stream byte width
`define COBS_BYTE_W 8

// each FIFO must hold a whole 254-byte group before its code exists
`define COBS_FIFO_DEPTH 256
`define COBS_FIFO_AW 8

// code of a group that hit the nonzero limit
`define COBS_MAX_CODE 255

`endif

// ==== hdl/cobs_pkg.sv ====
// COBS encoder types
// FSM state encodings and the fixed code values

package cobs_pkg;

    // input side FSM
    typedef enum logic [1:0] {
        SEG_IDLE       = 2'd0,
        SEG_RUN        = 2'd1,
        SEG_FINAL_CODE = 2'd2,
        SEG_TERMINATOR = 2'd3
    } seg_state_t;

    // output side FSM
    typedef enum logic [0:0] {
        EMIT_CODE = 1'b0,
        EMIT_DATA = 1'b1
    } emit_state_t;

    localparam stream_pkg::byte_t CODE_TERM  = 8'd0;
    localparam stream_pkg::byte_t CODE_EMPTY = 8'd1;
    localparam stream_pkg::byte_t CODE_FIRST = 8'd2;

endpackage

// ==== hdl/cobs_segmenter.sv ====
// COBS input segmenter
// splits frames into groups, data bytes to one FIFO and codes to the other

`timescale 1ns/1ps

`include "cobs_macros.svh"

module cobs_segmenter (
    input  logic               clk,
    input  logic               rst,
    input  stream_pkg::byte_t  s_tdata,
    input  logic               s_tvalid,
    output logic               s_tready,
    input  logic               s_tlast,
    output stream_pkg::byte_t  data_tdata,
    output logic               data_tvalid,
    input  logic               data_tready,
    output stream_pkg::byte_t  code_tdata,
    output logic               code_tvalid,
    output logic               code_tlast,
    input  logic               code_tready
);

    cobs_pkg::seg_state_t  state;
    cobs_pkg::seg_state_t  state_next;
    // code value the current group would get if it closed now
    stream_pkg::byte_t     cnt;
    stream_pkg::byte_t     cnt_next;
    logic                  accept;

    assign s_tready = (state == cobs_pkg::SEG_IDLE || state == cobs_pkg::SEG_RUN) &&
                      data_tready && code_tready;
    assign accept   = s_tvalid && s_tready;

    always_comb begin
        state_next  = state;
        cnt_next    = cnt;
        data_tdata  = s_tdata;
        data_tvalid = 1'b0;
        code_tdata  = cobs_pkg::CODE_EMPTY;
        code_tvalid = 1'b0;
        code_tlast  = 1'b0;

        case (state)
            cobs_pkg::SEG_IDLE, cobs_pkg::SEG_RUN: begin
                if (accept) begin
                    if (s_tdata == '0) begin
                        // a zero closes the group, which is empty in idle
                        code_tvalid = 1'b1;
                        code_tdata  = (state == cobs_pkg::SEG_IDLE) ?
                                      cobs_pkg::CODE_EMPTY : cnt;
                        state_next  = s_tlast ? cobs_pkg::SEG_FINAL_CODE :
                                                cobs_pkg::SEG_IDLE;
                    end else begin
                        data_tvalid = 1'b1;
                        state_next  = cobs_pkg::SEG_RUN;
                        if (state == cobs_pkg::SEG_IDLE) begin
                            cnt_next = cobs_pkg::CODE_FIRST;
                        end else begin
                            cnt_next = cnt + 1'b1;
                        end
                        // 254 nonzero bytes fill a group
                        if (state == cobs_pkg::SEG_RUN &&
                            cnt == stream_pkg::byte_t'(`COBS_MAX_CODE - 1)) begin
                            code_tvalid = 1'b1;
                            code_tdata  = stream_pkg::byte_t'(`COBS_MAX_CODE);
                            cnt_next    = 8'd1;
                        end
                        // on a full group this code is also 255 and replaces the one above
                        if (s_tlast) begin
                            code_tvalid = 1'b1;
                            code_tdata  = (state == cobs_pkg::SEG_IDLE) ?
                                          cobs_pkg::CODE_FIRST : cnt + 1'b1;
                            state_next  = cobs_pkg::SEG_TERMINATOR;
                        end
                    end
                end
            end
            cobs_pkg::SEG_FINAL_CODE: begin
                // frame ended on a zero so the trailing empty group still needs its code
                code_tvalid = 1'b1;
                code_tdata  = cobs_pkg::CODE_EMPTY;
                if (code_tready) begin
                    state_next = cobs_pkg::SEG_TERMINATOR;
                end
            end
            default: begin
                code_tvalid = 1'b1;
                code_tdata  = cobs_pkg::CODE_TERM;
                code_tlast  = 1'b1;
                if (code_tready) begin
                    state_next = cobs_pkg::SEG_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cobs_pkg::SEG_IDLE;
            cnt   <= cobs_pkg::CODE_FIRST;
        end else begin
            state <= state_next;
            cnt   <= cnt_next;
        end
    end

    // group codes never wrap to zero, so only the terminator carries code zero
    a_term_code: assert property (@(posedge clk) disable iff (rst)
        code_tvalid && code_tready && code_tdata == cobs_pkg::CODE_TERM
        |-> code_tlast);

endmodule

// ==== hdl/skid_buffer.sv ====
// output skid buffer
// registered valid, data and last, with a registered upstream ready

`timescale 1ns/1ps

module skid_buffer (
    input  logic               clk,
    input  logic               rst,
    input  stream_pkg::byte_t  int_tdata,
    input  logic               int_tvalid,
    input  logic               int_tlast,
    output logic               int_tready,
    output stream_pkg::byte_t  m_tdata,
    output logic               m_tvalid,
    output logic               m_tlast,
    input  logic               m_tready
);

    stream_pkg::byte_t  tmp_tdata;
    logic               tmp_tlast;
    logic               tmp_tvalid;
    logic               int_to_out;
    logic               int_to_tmp;
    logic               tmp_to_out;

    // upstream may keep sending if the sink drains or both slots are empty
    always_comb begin
        int_to_out = int_tready && (m_tready || !m_tvalid);
        int_to_tmp = int_tready && !m_tready && m_tvalid;
        tmp_to_out = !int_tready && m_tready;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_tvalid   <= 1'b0;
            tmp_tvalid <= 1'b0;
            int_tready <= 1'b0;
        end else begin
            int_tready <= m_tready || (!tmp_tvalid && !m_tvalid);
            if (int_to_out) begin
                m_tvalid <= int_tvalid;
            end else if (tmp_to_out) begin
                m_tvalid   <= tmp_tvalid;
                tmp_tvalid <= 1'b0;
            end
            if (int_to_tmp) begin
                tmp_tvalid <= int_tvalid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (int_to_out) begin
            m_tdata <= int_tdata;
            m_tlast <= int_tlast;
        end else if (tmp_to_out) begin
            m_tdata <= tmp_tdata;
            m_tlast <= tmp_tlast;
        end
        if (int_to_tmp) begin
            tmp_tdata <= int_tdata;
            tmp_tlast <= int_tlast;
        end
    end

    a_hold_stalled: assert property (@(posedge clk) disable iff (rst)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tlast));

endmodule

// ==== hdl/stream_pkg.sv ====
// stream byte type
// shared by every block on the byte datapath

`include "cobs_macros.svh"

package stream_pkg;

    // one byte on any valid/ready link
    typedef logic [`COBS_BYTE_W-1:0] byte_t;

endpackage

// ==== src.f ====
+incdir+hdl
hdl/stream_pkg.sv
hdl/cobs_pkg.sv
hdl/byte_fifo.sv
hdl/cobs_segmenter.sv
hdl/cobs_emitter.sv
hdl/skid_buffer.sv
hdl/cobs_encode.sv
dv/cobs_model.sv
dv/cobs_encode_tb.sv
